// ==== vlog.f ====
common/rv_decode_pkg.sv
decode/instr_field_decoder.sv
decode/alu_control_decoder.sv
src/register_file.sv
decode/decode_read.sv
src/decode_stage_top.sv
sim/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module decode_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdecode_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb;
    import rv_decode_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] instr;
    logic        stall;
    logic        bubble;
    logic        we;
    logic [4:0]  wa;
    logic [31:0] wd;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [3:0]  alu_op;
    logic        add_rshift_type;
    logic        shift_imm;
    logic        a_sel;
    logic        b_sel;
    logic        reg_we;
    logic        mem_we;
    logic        mem_rr;
    logic        csr_write;
    logic        csr_imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2_shamt;
    logic [31:0] imm;

    // Reference model state.
    logic [3:0]  exp_alu_op;
    logic [5:0]  exp_ctl;        // {a_sel, b_sel, reg_we, mem_we, mem_rr, csr_write}.
    logic        exp_rshift;
    logic        exp_shift_imm;
    logic        exp_csr_imm;
    logic [4:0]  exp_rd;
    logic [4:0]  exp_rs1;
    logic [4:0]  exp_rs2;
    logic [31:0] exp_imm;
    logic [31:0] reg_model [0:31]; // Shadow of the register file.
    int          errors;
    int          checks;

    decode_stage_top u_decode_stage_top (.*);

    always #2 clk = ~clk;

    // ============================================================
    // Helpers.
    // ============================================================
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected 0x%08h, got 0x%08h",
                     $realtime, name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    // Decode rules of the stage, taken from the RV32I encoding.
    task automatic model_decode(input logic [31:0] w);
        logic [2:0] f3;
        logic [3:0] f3_op;
        f3            = w[14:12];
        exp_rd        = w[11:7];
        exp_rs1       = w[19:15];
        exp_rs2       = w[24:20];
        exp_rshift    = w[30];
        exp_csr_imm   = (f3 == fnc_rwi);
        exp_shift_imm = (w[6:0] == opc_ari_itype) && (f3 == fnc_sll || f3 == fnc_srl_sra);
        case (f3)
            fnc_add_sub: f3_op = (w[6:0] == opc_ari_rtype && w[30]) ? alu_sub : alu_add;
            fnc_sll:     f3_op = alu_sll;
            fnc_slt:     f3_op = alu_slt;
            fnc_sltu:    f3_op = alu_sltu;
            fnc_xor:     f3_op = alu_xor;
            fnc_srl_sra: f3_op = w[30] ? alu_sra : alu_srl;
            fnc_or:      f3_op = alu_or;
            default:     f3_op = alu_and;
        endcase
        case (w[6:0])
            opc_lui, opc_auipc, opc_jal: exp_ctl = 6'b011000;
            opc_branch:                  exp_ctl = 6'b010000;
            opc_jalr, opc_ari_itype:     exp_ctl = 6'b111000;
            opc_load:                    exp_ctl = 6'b111010;
            opc_store:                   exp_ctl = 6'b110100;
            opc_ari_rtype:               exp_ctl = 6'b101000;
            opc_csr:                     exp_ctl = 6'b000001;
            default:                     exp_ctl = 6'b000000;
        endcase
        if (w[6:0] == opc_lui)
            exp_alu_op = alu_pass_b;
        else if (w[6:0] == opc_ari_itype || w[6:0] == opc_ari_rtype)
            exp_alu_op = f3_op;
        else
            exp_alu_op = alu_add;
        case (w[6:0])
            opc_jalr, opc_load, opc_ari_itype, opc_csr:
                exp_imm = {{20{w[31]}}, w[31:20]};
            opc_store:  exp_imm = {{20{w[31]}}, w[31:25], w[11:7]};
            opc_branch: exp_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            opc_lui, opc_auipc: exp_imm = {w[31:12], 12'b0};
            opc_jal:    exp_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:    exp_imm = '0;
        endcase
    endtask

    task automatic check_decode();
        check("alu_op", 32'(exp_alu_op), 32'(alu_op));
        check("add_rshift_type", 32'(exp_rshift), 32'(add_rshift_type));
        check("shift_imm", 32'(exp_shift_imm), 32'(shift_imm));
        check("a_sel", 32'(exp_ctl[5]), 32'(a_sel));
        check("b_sel", 32'(exp_ctl[4]), 32'(b_sel));
        check("reg_we", 32'(exp_ctl[3]), 32'(reg_we));
        check("mem_we", 32'(exp_ctl[2]), 32'(mem_we));
        check("mem_rr", 32'(exp_ctl[1]), 32'(mem_rr));
        check("csr_write", 32'(exp_ctl[0]), 32'(csr_write));
        check("csr_imm", 32'(exp_csr_imm), 32'(csr_imm));
        check("rd", 32'(exp_rd), 32'(rd));
        check("rs1", 32'(exp_rs1), 32'(rs1));
        check("rs2_shamt", 32'(exp_rs2), 32'(rs2_shamt));
        check("imm", exp_imm, imm);
    endtask

    task automatic drive_and_check(input logic [31:0] w);
        instr = w;
        next_cycle();
        model_decode(w);
        check_decode();
    endtask

    task automatic check_encoded_imm(input logic [31:0] w, input logic [31:0] expected_imm);
        instr = w;
        next_cycle();
        model_decode(w);
        exp_imm = expected_imm; // Immediate as it was encoded.
        check_decode();
    endtask

    task automatic wait_reset_state(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 16 && !ok; n++) begin
            if (!reg_we && !mem_we && !mem_rr && !csr_write && alu_op == alu_add)
                ok = 1'b1;
            else
                next_cycle();
        end
    endtask

    // ============================================================
    // Directed tests.
    // ============================================================
    task automatic test_reset();
        check("alu_op", 32'(alu_add), 32'(alu_op));
        check("enables", 32'd0, 32'({reg_we, mem_we, mem_rr, csr_write}));
        check("selects", 32'd0,
              32'({add_rshift_type, shift_imm, a_sel, b_sel, csr_imm}));
        check("imm", 32'd0, imm);
        check("rd", 32'd0, 32'(rd));
        check("rs1", 32'd0, 32'(rs1));
        check("rs2_shamt", 32'd0, 32'(rs2_shamt));
    endtask

    task automatic test_alu_decode();
        logic [31:0] w;
        for (int f = 0; f < 8; f++) begin
            for (int b = 0; b < 2; b++) begin
                w = $urandom;
                w[30] = b[0];
                w[14:12] = 3'(f);
                w[6:0] = opc_ari_rtype;
                drive_and_check(w);
                w[6:0] = opc_ari_itype;
                drive_and_check(w);
            end
        end
        drive_and_check({7'b0100000, 5'd2, 5'd1, fnc_add_sub, 5'd3, opc_ari_rtype}); // SUB
        check("alu_op", 32'(alu_sub), 32'(alu_op));
        drive_and_check({7'b0100000, 5'd2, 5'd1, fnc_srl_sra, 5'd3, opc_ari_rtype}); // SRA
        check("alu_op", 32'(alu_sra), 32'(alu_op));
        drive_and_check({7'b0100000, 5'd7, 5'd1, fnc_srl_sra, 5'd3, opc_ari_itype}); // SRAI
        check("alu_op", 32'(alu_sra), 32'(alu_op));
        drive_and_check({12'h400, 5'd1, fnc_add_sub, 5'd3, opc_ari_itype}); // ADDI stays add.
        check("alu_op", 32'(alu_add), 32'(alu_op));
    endtask

    task automatic test_immediates();
        logic [31:0] r;
        logic [31:0] sx;
        logic [4:0]  rd_f;
        logic [4:0]  rs1_f;
        logic [4:0]  rs2_f;
        for (int n = 0; n < 8; n++) begin
            r     = $urandom;
            rd_f  = 5'($urandom);
            rs1_f = 5'($urandom);
            rs2_f = 5'($urandom);
            sx = {{20{r[11]}}, r[11:0]};
            check_encoded_imm({r[11:0], rs1_f, 3'b000, rd_f, opc_ari_itype}, sx);
            check_encoded_imm({r[11:5], rs2_f, rs1_f, 3'b010, r[4:0], opc_store}, sx);
            sx = {{19{r[12]}}, r[12:1], 1'b0};
            check_encoded_imm({r[12], r[10:5], rs2_f, rs1_f, 3'b000, r[4:1], r[11], opc_branch},
                              sx);
            check_encoded_imm({r[31:12], rd_f, opc_lui}, {r[31:12], 12'b0});
            sx = {{11{r[20]}}, r[20:1], 1'b0};
            check_encoded_imm({r[20], r[10:1], r[11], r[19:12], rd_f, opc_jal}, sx);
        end
    endtask

    task automatic test_opcodes();
        logic [6:0]  opcs [0:9];
        logic [31:0] w;
        opcs = '{opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load,
                 opc_store, opc_csr, 7'b1111111, 7'b0001011};
        for (int k = 0; k < 10; k++) begin
            for (int n = 0; n < 3; n++) begin
                w = $urandom;
                w[6:0] = opcs[k];
                if (n == 1)
                    w[14:12] = fnc_rwi;
                else if (n == 2)
                    w[14:12] = fnc_rw;
                drive_and_check(w);
            end
        end
        drive_and_check({12'h305, 5'd4, fnc_rwi, 5'd1, opc_csr}); // CSRRWI
        check("csr_imm", 32'd1, 32'(csr_imm));
        drive_and_check(32'hffff_ffff);
        check("enables", 32'd0, 32'({reg_we, mem_we, mem_rr, csr_write}));
    endtask

    task automatic test_register_file();
        logic [31:0] v;
        logic [4:0]  a;
        logic [4:0]  b;
        for (int i = 0; i < 32; i++) begin
            v  = $urandom;
            we = 1'b1;
            wa = 5'(i);
            wd = v;
            if (i != 0)
                reg_model[i] = v; // x0 write is dropped.
            next_cycle();
        end
        we = 1'b0;
        for (int n = 0; n < 24; n++) begin
            a = (n == 0) ? 5'd0 : 5'($urandom);
            b = (n == 1) ? 5'd0 : 5'($urandom);
            instr = {7'b0, b, a, 3'b000, 5'd1, opc_ari_rtype};
            #1;
            check("ra", reg_model[a], ra);
            check("rb", reg_model[b], rb);
            next_cycle();
        end
        // Same-cycle write shows on the read at once.
        for (int n = 0; n < 5; n++) begin
            a  = (n == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            v  = $urandom;
            we = 1'b1;
            wa = a;
            wd = v;
            if (a != 5'd0)
                reg_model[a] = v;
            instr = {7'b0, a, a, 3'b000, 5'd1, opc_ari_rtype};
            #1;
            check("ra", reg_model[a], ra);
            check("rb", reg_model[a], rb);
            next_cycle();
        end
        we = 1'b0;
    endtask

    task automatic test_pipeline_control();
        logic [31:0] load_w;
        logic [31:0] store_w;
        load_w  = {12'hff3, 5'd4, 3'b010, 5'd9, opc_load};
        store_w = {7'h12, 5'd6, 5'd4, 3'b010, 5'd8, opc_store};
        drive_and_check({12'h012, 5'd3, fnc_add_sub, 5'd5, opc_ari_itype});
        stall = 1'b1;
        instr = load_w;
        next_cycle();
        check_decode();        // Model untouched, outputs held.
        stall  = 1'b0;
        bubble = 1'b1;
        next_cycle();
        model_decode(load_w);
        exp_ctl[3:0] = 4'b0000;
        check_decode();
        check("imm", 32'hffff_fff3, imm);
        stall = 1'b1;          // Stall over bubble.
        instr = store_w;
        next_cycle();
        check_decode();
        stall  = 1'b0;
        bubble = 1'b0;
        drive_and_check(store_w);
    endtask

    // ============================================================
    // Main sequence.
    // ============================================================
    initial begin
        bit ok;
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'h34b55e52));
        errors = 0;
        checks = 0;
        reset  = 1'b1;
        // SRAI, decodes unlike the reset values.
        instr  = {7'b0100000, 5'd7, 5'd3, fnc_srl_sra, 5'd9, opc_ari_itype};
        stall  = 1'b0;
        bubble = 1'b0;
        we     = 1'b0;
        wa     = '0;
        wd     = '0;
        for (int i = 0; i < 32; i++)
            reg_model[i] = '0;
        for (int i = 0; i < 8; i++)
            @(negedge clk);
        reset = 1'b0;
        wait_reset_state(ok);
        if (!ok) begin
            $display("Timeout: decode outputs never reached their reset values");
            $display("Regression failed");
            $finish;
        end else begin
            test_reset();
            test_alu_decode();
            test_immediates();
            test_opcodes();
            test_register_file();
            test_pipeline_control();
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0)
                $display("Regression passed");
            else
                $display("Regression failed");
            $finish;
        end
    end

endmodule

// ==== src/decode_stage_top.sv ====
`timescale 1ns/100ps

module decode_stage_top #(
    parameter bit write_forward = 1'b1
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [rv_decode_pkg::xlen-1:0]       instr,
    input  logic                                 stall,
    input  logic                                 bubble,
    input  logic                                 we,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_decode_pkg::xlen-1:0]       wd,
    output logic [rv_decode_pkg::xlen-1:0]       ra,
    output logic [rv_decode_pkg::xlen-1:0]       rb,
    output logic [3:0]                           alu_op,
    output logic                                 add_rshift_type,
    output logic                                 shift_imm,
    output logic                                 a_sel,
    output logic                                 b_sel,
    output logic                                 reg_we,
    output logic                                 mem_we,
    output logic                                 mem_rr,
    output logic                                 csr_write,
    output logic                                 csr_imm,
    output logic [rv_decode_pkg::reg_addr_w-1:0] rd,
    output logic [rv_decode_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_decode_pkg::reg_addr_w-1:0] rs2_shamt,
    output logic [rv_decode_pkg::xlen-1:0]       imm
);

    // Forwarding on, so writeback and decode can share a cycle.
    decode_read #(
        .write_forward (write_forward)
    ) u_decode_read (
        .clk             (clk),
        .reset           (reset),
        .instr           (instr),
        .stall           (stall),
        .bubble          (bubble),
        .we              (we),
        .wa              (wa),
        .wd              (wd),
        .ra              (ra),
        .rb              (rb),
        .alu_op          (alu_op),
        .add_rshift_type (add_rshift_type),
        .shift_imm       (shift_imm),
        .a_sel           (a_sel),
        .b_sel           (b_sel),
        .reg_we          (reg_we),
        .mem_we          (mem_we),
        .mem_rr          (mem_rr),
        .csr_write       (csr_write),
        .csr_imm         (csr_imm),
        .rd              (rd),
        .rs1             (rs1),
        .rs2_shamt       (rs2_shamt),
        .imm             (imm)
    );

endmodule

// ==== decode/decode_read.sv ====
`timescale 1ns/100ps

module decode_read #(
    parameter bit write_forward = 1'b1
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [rv_decode_pkg::xlen-1:0]       instr,
    input  logic                                 stall,
    input  logic                                 bubble,
    // Writeback port.
    input  logic                                 we,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_decode_pkg::xlen-1:0]       wd,
    // Operands, combinational from instr.
    output logic [rv_decode_pkg::xlen-1:0]       ra,
    output logic [rv_decode_pkg::xlen-1:0]       rb,
    // Registered decode.
    output logic [3:0]                           alu_op,
    output logic                                 add_rshift_type,
    output logic                                 shift_imm,
    output logic                                 a_sel,
    output logic                                 b_sel,
    output logic                                 reg_we,
    output logic                                 mem_we,
    output logic                                 mem_rr,
    output logic                                 csr_write,
    output logic                                 csr_imm,
    output logic [rv_decode_pkg::reg_addr_w-1:0] rd,
    output logic [rv_decode_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_decode_pkg::reg_addr_w-1:0] rs2_shamt,
    output logic [rv_decode_pkg::xlen-1:0]       imm
);
    import rv_decode_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd_d;
    logic [reg_addr_w-1:0] rs1_d;
    logic [reg_addr_w-1:0] rs2_shamt_d;
    logic [xlen-1:0]       imm_d;
    logic [3:0]            alu_op_d;
    logic                  a_sel_d;
    logic                  b_sel_d;
    logic                  reg_we_d;
    logic                  mem_we_d;
    logic                  mem_rr_d;
    logic                  csr_write_d;
    logic                  shift_imm_d;

    // ============================================================
    // Field, ALU and register-file blocks.
    // ============================================================
    instr_field_decoder u_fields (
        .instr     (instr),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7    (funct7),
        .rd        (rd_d),
        .rs1       (rs1_d),
        .rs2_shamt (rs2_shamt_d),
        .imm       (imm_d)
    );

    alu_control_decoder u_alu_dec (
        .opcode          (opcode),
        .funct3          (funct3),
        .add_rshift_type (funct7[5]),
        .alu_op          (alu_op_d)
    );

    register_file #(
        .write_forward (write_forward)
    ) u_regfile (
        .clk   (clk),
        .reset (reset),
        .we    (we),
        .ra1   (rs1_d),
        .ra2   (rs2_shamt_d),
        .wa    (wa),
        .wd    (wd),
        .rd1   (ra),
        .rd2   (rb)
    );

    // ============================================================
    // Select and enable controls.
    // ============================================================
    always_comb begin
        a_sel_d     = 1'b0; // Unknown opcode leaves all of these low.
        b_sel_d     = 1'b0;
        reg_we_d    = 1'b0;
        mem_we_d    = 1'b0;
        mem_rr_d    = 1'b0;
        csr_write_d = 1'b0;
        case (opcode)
            opc_lui, opc_auipc, opc_jal: begin
                b_sel_d  = 1'b1;
                reg_we_d = 1'b1;
            end
            opc_branch:    b_sel_d = 1'b1; // PC + offset.
            opc_jalr, opc_load: begin
                a_sel_d  = 1'b1;
                b_sel_d  = 1'b1;
                reg_we_d = 1'b1;
                mem_rr_d = (opcode == opc_load);
            end
            opc_store: begin
                a_sel_d  = 1'b1;
                b_sel_d  = 1'b1;
                mem_we_d = 1'b1;
            end
            opc_ari_itype: begin
                a_sel_d  = 1'b1;
                b_sel_d  = 1'b1;
                reg_we_d = 1'b1;
            end
            opc_ari_rtype: begin
                a_sel_d  = 1'b1;
                reg_we_d = 1'b1;
            end
            opc_csr:       csr_write_d = 1'b1;
            default:       ;
        endcase
    end

    assign shift_imm_d = (opcode == opc_ari_itype) &&
                         ((funct3 == fnc_sll) || (funct3 == fnc_srl_sra));

    // ============================================================
    // Pipeline register. Stall holds, bubble kills enables.
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op          <= alu_add;
            add_rshift_type <= 1'b0;
            shift_imm       <= 1'b0;
            a_sel           <= 1'b0;
            b_sel           <= 1'b0;
            reg_we          <= 1'b0;
            mem_we          <= 1'b0;
            mem_rr          <= 1'b0;
            csr_write       <= 1'b0;
            csr_imm         <= 1'b0;
            rd              <= '0;
            rs1             <= '0;
            rs2_shamt       <= '0;
            imm             <= '0;
        end else if (!stall) begin
            alu_op          <= alu_op_d;
            add_rshift_type <= funct7[5];
            shift_imm       <= shift_imm_d;
            a_sel           <= a_sel_d;
            b_sel           <= b_sel_d;
            reg_we          <= reg_we_d    && !bubble;
            mem_we          <= mem_we_d    && !bubble;
            mem_rr          <= mem_rr_d    && !bubble;
            csr_write       <= csr_write_d && !bubble;
            csr_imm         <= (funct3 == fnc_rwi);
            rd              <= rd_d;
            rs1             <= rs1_d;
            rs2_shamt       <= rs2_shamt_d;
            imm             <= imm_d;
        end
    end

    // Memory and CSR requests are exclusive toward later stages.
    a_one_request: assert property (@(posedge clk) disable iff (reset)
        $onehot0({mem_we, mem_rr, csr_write}));

    a_bubble_clears: assert property (@(posedge clk) disable iff (reset)
        (bubble && !stall) |=> !(reg_we || mem_we || mem_rr || csr_write));

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/100ps

module register_file #(
    parameter bit write_forward = 1'b1
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 we,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] ra1,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] ra2,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_decode_pkg::xlen-1:0]       wd,
    output logic [rv_decode_pkg::xlen-1:0]       rd1,
    output logic [rv_decode_pkg::xlen-1:0]       rd2
);
    import rv_decode_pkg::*;

    logic [xlen-1:0] mem [1:31]; // x0 has no storage.

    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        logic [xlen-1:0] data;
        data = '0;
        if (addr != '0) begin
            if (write_forward && we && (wa == addr))
                data = wd;    // Same-cycle write wins.
            else
                data = mem[addr];
        end
        return data;
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
    end

    always_comb begin
        rd2 = read_port(ra2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                mem[i] <= '0;
        end else if (we && (wa != '0)) begin
            mem[wa] <= wd;
        end
    end

endmodule

// ==== decode/alu_control_decoder.sv ====
`timescale 1ns/100ps

module alu_control_decoder (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       add_rshift_type,
    output logic [3:0] alu_op
);
    import rv_decode_pkg::*;

    logic [3:0] alu_funct3;
    logic       is_rtype;

    assign is_rtype = (opcode == opc_ari_rtype);

    // Shared funct3 map for OP and OP-IMM.
    always_comb begin
        case (funct3)
            fnc_add_sub: alu_funct3 = (is_rtype && add_rshift_type) ? alu_sub : alu_add;
            fnc_sll:     alu_funct3 = alu_sll;
            fnc_slt:     alu_funct3 = alu_slt;
            fnc_sltu:    alu_funct3 = alu_sltu;
            fnc_xor:     alu_funct3 = alu_xor;
            fnc_srl_sra: alu_funct3 = add_rshift_type ? alu_sra : alu_srl;
            fnc_or:      alu_funct3 = alu_or;
            default:     alu_funct3 = alu_and;
        endcase
    end

    always_comb begin
        case (opcode)
            opc_lui:       alu_op = alu_pass_b;
            opc_auipc,
            opc_jal,
            opc_jalr,
            opc_branch,
            opc_load,
            opc_store:     alu_op = alu_add; // Address or PC arithmetic.
            opc_ari_itype,
            opc_ari_rtype: alu_op = alu_funct3;
            default:       alu_op = alu_add; // CSR and unknown.
        endcase
    end

endmodule

// ==== decode/instr_field_decoder.sv ====
`timescale 1ns/100ps

module instr_field_decoder (
    input  rv_decode_pkg::rv_instr_u                 instr,
    output logic [6:0]                               opcode,
    output logic [2:0]                               funct3,
    output logic [6:0]                               funct7,
    output logic [rv_decode_pkg::reg_addr_w-1:0]     rd,
    output logic [rv_decode_pkg::reg_addr_w-1:0]     rs1,
    output logic [rv_decode_pkg::reg_addr_w-1:0]     rs2_shamt,
    output logic [rv_decode_pkg::xlen-1:0]           imm
);
    import rv_decode_pkg::*;

    logic [11:0] imm_hi;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // Register fields come from the R view.
    assign opcode    = instr.r.opcode;
    assign funct3    = instr.r.funct3;
    assign funct7    = instr.r.funct7;
    assign rd        = instr.r.rd;
    assign rs1       = instr.r.rs1;
    assign rs2_shamt = instr.r.rs2;   // Also the shamt of SLLI/SRLI/SRAI.

    assign imm_hi = instr.i.imm_hi;

    // ============================================================
    // Immediates per format.
    // ============================================================
    assign imm_i = {{20{imm_hi[11]}}, imm_hi};
    assign imm_s = {{20{funct7[6]}}, funct7, rd};

    // B splits bit 11 into rd[0] and drops bit 0.
    assign imm_b = {{19{funct7[6]}}, funct7[6], rd[0], funct7[5:0], rd[4:1], 1'b0};

    assign imm_u = {imm_hi, instr.i.rs1, instr.i.funct3, 12'b0};

    // J reuses the rs1/funct3 bits as imm[19:12].
    assign imm_j = {{11{imm_hi[11]}}, imm_hi[11], instr.i.rs1, instr.i.funct3,
                    imm_hi[0], imm_hi[10:1], 1'b0};

    always_comb begin
        case (opcode)
            opc_jalr,
            opc_load,
            opc_ari_itype,
            opc_csr:       imm = imm_i;
            opc_store:     imm = imm_s;
            opc_branch:    imm = imm_b;
            opc_lui,
            opc_auipc:     imm = imm_u;
            opc_jal:       imm = imm_j;
            default:       imm = '0; // R-type and unknown.
        endcase
    end

endmodule

// ==== common/rv_decode_pkg.sv ====
package rv_decode_pkg;

    // ============================================================
    // Widths.
    // ============================================================
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ============================================================
    // RV32I major opcodes.
    // ============================================================
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_ari_itype = 7'b0010011; // OP-IMM.
    localparam logic [6:0] opc_ari_rtype = 7'b0110011; // OP.
    localparam logic [6:0] opc_csr       = 7'b1110011; // SYSTEM.

    // ============================================================
    // funct3 codes.
    // ============================================================
    // Arithmetic and logic group.
    localparam logic [2:0] fnc_add_sub = 3'b000;
    localparam logic [2:0] fnc_sll     = 3'b001;
    localparam logic [2:0] fnc_slt     = 3'b010;
    localparam logic [2:0] fnc_sltu    = 3'b011;
    localparam logic [2:0] fnc_xor     = 3'b100;
    localparam logic [2:0] fnc_srl_sra = 3'b101;
    localparam logic [2:0] fnc_or      = 3'b110;
    localparam logic [2:0] fnc_and     = 3'b111;

    // CSR group.
    localparam logic [2:0] fnc_rw      = 3'b001; // CSRRW.
    localparam logic [2:0] fnc_rwi     = 3'b101; // CSRRWI, zimm in rs1 field.

    // ============================================================
    // ALU operation codes.
    // ============================================================
    // Low codes follow funct3 order, the rest sit above.
    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sll    = 4'd1;
    localparam logic [3:0] alu_slt    = 4'd2;
    localparam logic [3:0] alu_sltu   = 4'd3;
    localparam logic [3:0] alu_xor    = 4'd4;
    localparam logic [3:0] alu_srl    = 4'd5;
    localparam logic [3:0] alu_or     = 4'd6;
    localparam logic [3:0] alu_and    = 4'd7;
    localparam logic [3:0] alu_sub    = 4'd8;
    localparam logic [3:0] alu_sra    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10; // Result is operand B, for LUI.
    // Codes 11 to 15 are unused.

    // ============================================================
    // Instruction word.
    // ============================================================
    // Same 32 bits seen two ways. The R view gives funct7 and rs2,
    // the immediate view gives the 12 upper bits as one field.
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm_hi;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } rv_instr_u;

endpackage
